/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_uce -Mdir obj_dir

run: compile
	./obj_dir/Vtb_uce | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_uce.sv */
`timescale 1ns/10ps

module tb_uce;

  import uce_pkg::*;

  localparam int sets_lp   = 16;
  localparam int index_lp  = $clog2(sets_lp);
  localparam int timeout_lp = 400;

  typedef struct packed
  {
    mem_msg_s  cmd;
    tag_pkt_s  tag;
    data_pkt_s data;
  } expect_s;

  typedef struct packed
  {
    tag_pkt_s  tag;
    data_pkt_s data;
    mem_msg_s  resp;
  } done_s;

  logic            clk_i = 1'b0;
  logic            reset_i;
  lce_id_t         lce_id_i;
  cache_req_s      req_i;
  logic            req_v_i;
  logic            req_yumi_o;
  logic            busy_o;
  logic            complete_o;
  cache_req_meta_s meta_i;
  logic            meta_v_i;
  tag_pkt_s        tag_pkt_o;
  logic            tag_pkt_v_o;
  logic            tag_pkt_yumi_i;
  data_pkt_s       data_pkt_o;
  logic            data_pkt_v_o;
  logic            data_pkt_yumi_i;
  stat_pkt_s       stat_pkt_o;
  logic            stat_pkt_v_o;
  logic            stat_pkt_yumi_i;
  mem_msg_s        mem_cmd_o;
  logic            mem_cmd_v_o;
  logic            mem_cmd_ready_then_i;
  mem_msg_s        mem_resp_i;
  logic            mem_resp_v_i;
  logic            mem_resp_yumi_o;

  logic [31:0] rng = 32'h4b86f824;
  mem_msg_s    cmd_q[$];
  mem_msg_s    pend_q[$];
  int          clear_q[$];
  int          tag_clear_q[$];
  done_s       done_q[$];
  int          complete_cnt = 0;
  logic        resp_taken = 1'b0;
  logic        hold_resp = 1'b0;
  int          resp_delay = 3;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_errors;
  string       test_name = "none";

  uce_top #(.sets_p(sets_lp), .assoc_p(4), .max_credits_p(4)) u_dut
    (.clk_i                (clk_i)
     ,.reset_i             (reset_i)
     ,.lce_id_i            (lce_id_i)
     ,.req_i               (req_i)
     ,.req_v_i             (req_v_i)
     ,.req_yumi_o          (req_yumi_o)
     ,.busy_o              (busy_o)
     ,.complete_o          (complete_o)
     ,.meta_i              (meta_i)
     ,.meta_v_i            (meta_v_i)
     ,.tag_pkt_o           (tag_pkt_o)
     ,.tag_pkt_v_o         (tag_pkt_v_o)
     ,.tag_pkt_yumi_i      (tag_pkt_yumi_i)
     ,.data_pkt_o          (data_pkt_o)
     ,.data_pkt_v_o        (data_pkt_v_o)
     ,.data_pkt_yumi_i     (data_pkt_yumi_i)
     ,.stat_pkt_o          (stat_pkt_o)
     ,.stat_pkt_v_o        (stat_pkt_v_o)
     ,.stat_pkt_yumi_i     (stat_pkt_yumi_i)
     ,.mem_cmd_o           (mem_cmd_o)
     ,.mem_cmd_v_o         (mem_cmd_v_o)
     ,.mem_cmd_ready_then_i(mem_cmd_ready_then_i)
     ,.mem_resp_i          (mem_resp_i)
     ,.mem_resp_v_i        (mem_resp_v_i)
     ,.mem_resp_yumi_o     (mem_resp_yumi_o)
    );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // expected command and cache packets for one request
  function automatic expect_s expect_pkt(cache_req_s req, cache_req_meta_s meta,
                                         mem_msg_s resp);
    expect_s e;
    e = '0;
    e.cmd.lce_id = lce_id_i;
    case (req.msg_type)
      e_req_uc_store:
      begin
        e.cmd.msg_type = e_mem_uc_wr;
        e.cmd.addr     = req.addr;
        e.cmd.size     = req.size;
        e.cmd.data     = {64'h0, req.data};
      end
      e_req_uc_load:
      begin
        e.cmd.msg_type  = e_mem_uc_rd;
        e.cmd.addr      = req.addr;
        e.cmd.size      = req.size;
        e.data.opcode   = e_data_uncached;
        e.data.data     = {resp.data[63:0], resp.data[63:0]};
      end
      default:
      begin
        e.cmd.msg_type = e_mem_rd;
        e.cmd.addr     = {req.addr[31:4], 4'h0};
        e.cmd.size     = e_size_16;
        e.cmd.way      = meta.repl_way;
        e.tag.opcode   = e_tag_set_tag;
        e.tag.index    = index_t'(resp.addr[block_offset_w +: index_lp]);
        e.tag.way      = resp.way;
        e.tag.tag      = resp.addr[block_offset_w + index_lp +: 20];
        e.tag.state    = e_coh_m;
        e.data.opcode  = e_data_write;
        e.data.index   = e.tag.index;
        e.data.way     = resp.way;
        e.data.data    = resp.data;
      end
    endcase
    return e;
  endfunction

  task automatic check_val(input string what, input logic [255:0] exp,
                           input logic [255:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic note_fail(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
  endtask

  task automatic give_up(input string why);
    $display("%s: timed out, %s", test_name, why);
    $display("Something failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == test_errors)
      $display("test %s passed", test_name);
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - test_errors);
    end
  endtask

  task automatic send_req(input cache_req_s req);
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    req_i   = req;
    req_v_i = 1'b1;
    while (n < timeout_lp)
    begin
      @(negedge clk_i);
      if (req_yumi_o)
        break;
      n++;
    end
    if (n >= timeout_lp)
      give_up("request never accepted");
    @(posedge clk_i);
    #1;
    req_v_i = 1'b0;
  endtask

  task automatic wait_cmd(output mem_msg_s cmd);
    int n;
    n = 0;
    while (cmd_q.size() == 0 && n < timeout_lp)
    begin
      @(posedge clk_i);
      n++;
    end
    if (cmd_q.size() == 0)
      give_up("no memory command fired");
    else
      cmd = cmd_q.pop_front();
  endtask

  task automatic wait_done(output done_s d);
    int n;
    n = 0;
    while (done_q.size() == 0 && n < timeout_lp)
    begin
      @(posedge clk_i);
      n++;
    end
    if (done_q.size() == 0)
      give_up("response packets never completed");
    else
      d = done_q.pop_front();
  endtask

  task automatic wait_responses();
    int n;
    n = 0;
    while ((pend_q.size() != 0 || mem_resp_v_i) && n < timeout_lp)
    begin
      @(posedge clk_i);
      n++;
    end
    if (pend_q.size() != 0 || mem_resp_v_i)
      give_up("memory responses never drained");
  endtask

  // clear packets must walk every index once while busy stays high
  task automatic wait_clear();
    int n;
    int start;
    start = complete_cnt;
    n = 0;
    while (n < timeout_lp)
    begin
      @(negedge clk_i);
      if (complete_o)
        break;
      assert (busy_o)
      else
        note_fail("busy_o dropped before the clear finished");
      n++;
    end
    if (n >= timeout_lp)
      give_up("clear never completed");
    @(negedge clk_i);
    assert (!busy_o)
    else
      note_fail("busy_o still high after the clear finished");
    repeat (3) @(posedge clk_i);
    check_val("complete pulses", start + 1, complete_cnt);
    check_val("cleared sets", sets_lp, clear_q.size());
    for (int i = 0; i < clear_q.size(); i++)
      check_val("clear index", i, clear_q[i]);
    check_val("cleared tag sets", sets_lp, tag_clear_q.size());
    for (int i = 0; i < tag_clear_q.size(); i++)
      check_val("tag clear index", i, tag_clear_q[i]);
  endtask

  // random yumis on the cache memory packets
  always @(posedge clk_i)
  begin : yumi_drive
    logic [31:0] r;
    #1;
    r = next_rand();
    tag_pkt_yumi_i  = r[0] | r[1];
    data_pkt_yumi_i = r[2] | r[3];
    stat_pkt_yumi_i = r[4] | r[5];
  end

  // the memory responder answers each command a few cycles after it fires
  always @(posedge clk_i)
  begin : responder
    mem_msg_s c;
    #1;
    if (mem_resp_v_i && resp_taken)
      mem_resp_v_i = 1'b0;
    if (!mem_resp_v_i && !hold_resp && pend_q.size() != 0)
    begin
      if (resp_delay == 0)
      begin
        c = pend_q.pop_front();
        if (c.msg_type inside {e_mem_rd, e_mem_uc_rd})
          c.data = {next_rand(), next_rand(), next_rand(), next_rand()};
        mem_resp_i   = c;
        mem_resp_v_i = 1'b1;
        resp_delay   = 3;
      end
      else
        resp_delay--;
    end
  end

  // sample outputs at the falling edge
  always @(negedge clk_i)
  begin : monitor
    done_s d;
    if (!reset_i)
    begin
      if (mem_cmd_v_o)
      begin
        cmd_q.push_back(mem_cmd_o);
        pend_q.push_back(mem_cmd_o);
      end
      if (tag_pkt_v_o && stat_pkt_v_o && tag_pkt_yumi_i && stat_pkt_yumi_i)
      begin
        clear_q.push_back(int'(stat_pkt_o.index));
        tag_clear_q.push_back(int'(tag_pkt_o.index));
        check_val("tag clear opcode", e_tag_set_clear, tag_pkt_o.opcode);
        check_val("status clear opcode", e_stat_set_clear, stat_pkt_o.opcode);
      end
      if (complete_o)
        complete_cnt++;
      if (complete_o && data_pkt_v_o)
      begin
        d.tag  = tag_pkt_o;
        d.data = data_pkt_o;
        d.resp = mem_resp_i;
        done_q.push_back(d);
      end
      if (mem_resp_v_i && mem_resp_i.msg_type inside {e_mem_wr, e_mem_uc_wr})
        assert (mem_resp_yumi_o)
        else
          note_fail("write response was not taken in the cycle it was valid");
      resp_taken = mem_resp_v_i & mem_resp_yumi_o;
    end
  end

  initial
  begin
    cache_req_s      req;
    cache_req_meta_s meta;
    mem_msg_s        cmd;
    done_s           d;
    expect_s         e;
    int              start;

    reset_i              = 1'b1;
    lce_id_i             = 4'h3;
    req_i                = '0;
    req_v_i              = 1'b0;
    meta_i               = '0;
    meta_v_i             = 1'b0;
    tag_pkt_yumi_i       = 1'b0;
    data_pkt_yumi_i      = 1'b0;
    stat_pkt_yumi_i      = 1'b0;
    mem_cmd_ready_then_i = 1'b1;
    mem_resp_i           = '0;
    mem_resp_v_i         = 1'b0;
    meta                 = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    start_test("clear_after_reset");
    wait_clear();
    finish_test();

    start_test("uc_store");
    req          = '0;
    req.msg_type = e_req_uc_store;
    req.addr     = next_rand();
    req.size     = e_size_8;
    req.data     = {next_rand(), next_rand()};
    send_req(req);
    wait_cmd(cmd);
    e = expect_pkt(req, meta, '0);
    check_val("command", e.cmd, cmd);
    wait_responses();
    finish_test();

    start_test("uc_load");
    req          = '0;
    req.msg_type = e_req_uc_load;
    req.addr     = next_rand();
    req.size     = e_size_8;
    start        = complete_cnt;
    send_req(req);
    wait_cmd(cmd);
    e = expect_pkt(req, meta, '0);
    check_val("command", e.cmd, cmd);
    wait_done(d);
    e = expect_pkt(req, meta, d.resp);
    check_val("data opcode", e.data.opcode, d.data.opcode);
    check_val("data", e.data.data, d.data.data);
    repeat (2) @(posedge clk_i);
    check_val("complete pulses", start + 1, complete_cnt);
    finish_test();

    start_test("miss_fill");
    meta.repl_way = way_t'(next_rand() % 4);
    @(posedge clk_i);
    #1;
    meta_i   = meta;
    meta_v_i = 1'b1;
    req          = '0;
    req.msg_type = e_req_miss_load;
    req.addr     = next_rand();
    req.size     = e_size_8;
    send_req(req);
    wait_cmd(cmd);
    e = expect_pkt(req, meta, '0);
    check_val("command", e.cmd, cmd);
    wait_done(d);
    e = expect_pkt(req, meta, d.resp);
    check_val("tag packet", e.tag, d.tag);
    check_val("data packet", e.data, d.data);
    #1;
    meta_v_i = 1'b0;
    wait_responses();
    finish_test();

    start_test("credits");
    hold_resp = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      req          = '0;
      req.msg_type = e_req_uc_store;
      req.addr     = next_rand();
      req.size     = e_size_8;
      req.data     = {next_rand(), next_rand()};
      send_req(req);
      wait_cmd(cmd);
      e = expect_pkt(req, meta, '0);
      check_val("store command", e.cmd, cmd);
    end
    @(posedge clk_i);
    #1;
    req_i.addr = next_rand();
    req_v_i    = 1'b1;
    repeat (6)
    begin
      @(negedge clk_i);
      assert (!req_yumi_o && busy_o)
      else
        note_fail("request accepted or engine not busy with credits full");
    end
    @(posedge clk_i);
    #1;
    req_v_i   = 1'b0;
    hold_resp = 1'b0;
    wait_responses();
    clear_q.delete();
    tag_clear_q.delete();
    req          = '0;
    req.msg_type = e_req_clear;
    send_req(req);
    wait_clear();
    finish_test();

    start_test("clear_request");
    clear_q.delete();
    tag_clear_q.delete();
    send_req(req);
    wait_clear();
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* hdl/uce_credit_counter.sv */
`timescale 1ns/10ps

module uce_credit_counter
  #(parameter int max_credits_p = 4)
  (input          clk_i
   , input        reset_i
   , input        cmd_fire_i
   , input        resp_yumi_i
   , output logic full_o
   , output logic empty_o
  );

  localparam int count_w_lp = $clog2(max_credits_p + 1);

  logic [count_w_lp-1:0] count_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_fire_i & ~resp_yumi_i)
      count_r <= count_r + 1'b1;
    else if (~cmd_fire_i & resp_yumi_i)
      count_r <= count_r - 1'b1;
  end

  assign full_o  = (count_r == count_w_lp'(max_credits_p));
  assign empty_o = (count_r == '0);

  // a command fired with no credit left
  a_no_overflow: assert property
    (@(posedge clk_i) disable iff (reset_i) (full_o & cmd_fire_i) |-> resp_yumi_i);

  // a response taken with nothing outstanding
  a_no_underflow: assert property
    (@(posedge clk_i) disable iff (reset_i) (empty_o & resp_yumi_i) |-> cmd_fire_i);

endmodule

/* hdl/uce_ctrl.sv */
`timescale 1ns/10ps

module uce_ctrl
  #(parameter int sets_p  = 64
    , parameter int assoc_p = 8)
  (input                              clk_i
   , input                            reset_i
   , input  uce_pkg::lce_id_t         lce_id_i
   , input  uce_pkg::cache_req_s      req_i
   , input                            req_v_i
   , output logic                     req_yumi_o
   , output logic                     busy_o
   , output logic                     complete_o
   , input  uce_pkg::cache_req_s      held_req_i
   , input                            held_req_v_i
   , input  uce_pkg::cache_req_meta_s meta_i
   , input                            meta_v_i
   , input                            credits_full_i
   , input                            credits_empty_i
   , output uce_pkg::tag_pkt_s        tag_pkt_o
   , output logic                     tag_pkt_v_o
   , input                            tag_pkt_yumi_i
   , output uce_pkg::data_pkt_s       data_pkt_o
   , output logic                     data_pkt_v_o
   , input                            data_pkt_yumi_i
   , output uce_pkg::stat_pkt_s       stat_pkt_o
   , output logic                     stat_pkt_v_o
   , input                            stat_pkt_yumi_i
   , output uce_pkg::mem_msg_s        mem_cmd_o
   , output logic                     mem_cmd_v_o
   , input                            mem_cmd_ready_then_i
   , input  uce_pkg::mem_msg_s        mem_resp_i
   , input                            mem_resp_v_i
   , output logic                     mem_resp_yumi_o
  );

  import uce_pkg::*;

  localparam int index_w_lp = $clog2(sets_p);
  localparam int tag_lsb_lp = block_offset_w + index_w_lp;

  ctrl_state_e state_r, state_n;
  index_t      index_r;
  logic        index_up;
  logic        resp_yumi_lo;
  logic        cmd_seen_r;

  wire is_reset = (state_r == e_reset);
  wire is_clear = (state_r == e_clear);
  wire index_done = (index_r == index_t'(sets_p - 1));

  wire uc_store_v_li = req_v_i & (req_i.msg_type == e_req_uc_store);
  wire clear_v_li    = req_v_i & (req_i.msg_type == e_req_clear);

  wire miss_v_li    = held_req_v_i
                      & (held_req_i.msg_type inside {e_req_miss_load, e_req_miss_store});
  wire uc_load_v_li = held_req_v_i & (held_req_i.msg_type == e_req_uc_load);

  wire store_resp_v_li = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_wr, e_mem_uc_wr});
  wire load_resp_v_li  = mem_resp_v_i & (mem_resp_i.msg_type inside {e_mem_rd, e_mem_uc_rd});

  // fill location comes from the response, not the held request
  wire index_t resp_index = index_t'(mem_resp_i.addr[block_offset_w +: index_w_lp]);
  wire ptag_t  resp_tag   = mem_resp_i.addr[tag_lsb_lp +: $bits(ptag_t)];

  // write acks are taken right away, in any state but reset
  assign mem_resp_yumi_o = resp_yumi_lo | (store_resp_v_li & ~is_reset);
  assign busy_o = is_reset | is_clear | credits_full_i;

  always_comb
  begin
    req_yumi_o       = 1'b0;
    complete_o       = 1'b0;
    index_up         = 1'b0;
    resp_yumi_lo     = 1'b0;
    tag_pkt_o        = '0;
    tag_pkt_v_o      = 1'b0;
    data_pkt_o       = '0;
    data_pkt_v_o     = 1'b0;
    stat_pkt_o       = '0;
    stat_pkt_v_o     = 1'b0;
    mem_cmd_o        = '0;
    mem_cmd_o.lce_id = lce_id_i;
    mem_cmd_v_o      = 1'b0;
    state_n          = state_r;

    unique case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_pkt_o.opcode  = e_tag_set_clear;
        tag_pkt_o.index   = index_r;
        tag_pkt_v_o       = 1'b1;
        stat_pkt_o.opcode = e_stat_set_clear;
        stat_pkt_o.index  = index_r;
        stat_pkt_v_o      = 1'b1;
        index_up          = tag_pkt_yumi_i & stat_pkt_yumi_i;
        complete_o        = index_done & index_up;
        if (complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        req_yumi_o = req_v_i & mem_cmd_ready_then_i & ~credits_full_i;
        if (uc_store_v_li)
        begin
          mem_cmd_o.msg_type = e_mem_uc_wr;
          mem_cmd_o.addr     = req_i.addr;
          mem_cmd_o.size     = req_i.size;
          mem_cmd_o.data     = block_t'(req_i.data);
          mem_cmd_v_o        = req_yumi_o;
        end
        else if (req_yumi_o)
          state_n = clear_v_li ? e_clear : e_send;
      end
      e_send:
      begin
        if (miss_v_li)
        begin
          mem_cmd_o.msg_type = e_mem_rd;
          mem_cmd_o.addr     = {held_req_i.addr[$bits(paddr_t)-1:block_offset_w],
                                block_offset_w'(0)};
          mem_cmd_o.size     = e_size_16;
          mem_cmd_o.way      = meta_i.repl_way;
          mem_cmd_v_o        = mem_cmd_ready_then_i & meta_v_i;
          if (mem_cmd_v_o)
            state_n = e_fill_wait;
        end
        else if (uc_load_v_li)
        begin
          mem_cmd_o.msg_type = e_mem_uc_rd;
          mem_cmd_o.addr     = held_req_i.addr;
          mem_cmd_o.size     = held_req_i.size;
          mem_cmd_v_o        = mem_cmd_ready_then_i;
          if (mem_cmd_v_o)
            state_n = e_uc_read_wait;
        end
      end
      e_fill_wait:
      begin
        // fill lands in M so no further coherence traffic is needed
        tag_pkt_o.opcode  = e_tag_set_tag;
        tag_pkt_o.index   = resp_index;
        tag_pkt_o.way     = mem_resp_i.way;
        tag_pkt_o.tag     = resp_tag;
        tag_pkt_o.state   = e_coh_m;
        tag_pkt_v_o       = load_resp_v_li;
        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index  = resp_index;
        data_pkt_o.way    = mem_resp_i.way;
        data_pkt_o.data   = mem_resp_i.data;
        data_pkt_v_o      = load_resp_v_li;
        complete_o        = load_resp_v_li & tag_pkt_yumi_i & data_pkt_yumi_i;
        resp_yumi_lo      = complete_o;
        if (complete_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.data   = {($bits(block_t) / $bits(dword_t)){mem_resp_i.data[0 +: 64]}};
        data_pkt_v_o      = load_resp_v_li;
        complete_o        = load_resp_v_li & data_pkt_yumi_i;
        resp_yumi_lo      = complete_o;
        if (complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_reset;
      index_r    <= '0;
      cmd_seen_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (index_up)
        index_r <= index_done ? '0 : index_r + 1'b1;
      if (mem_cmd_v_o)
        cmd_seen_r <= 1'b1;
    end
  end

  a_state_legal: assert property
    (@(posedge clk_i) disable iff (reset_i)
     state_r inside {e_reset, e_clear, e_ready, e_send, e_fill_wait, e_uc_read_wait});

  // nothing can be outstanding before the first command goes out
  a_empty_until_first_cmd: assert property
    (@(posedge clk_i) disable iff (reset_i) !cmd_seen_r |-> credits_empty_i);

  a_fill_way_in_range: assert property
    (@(posedge clk_i) disable iff (reset_i)
     (mem_cmd_v_o && mem_cmd_o.msg_type == e_mem_rd) |-> (int'(mem_cmd_o.way) < assoc_p));

endmodule

/* hdl/uce_pkg.sv */
package uce_pkg;

  typedef logic [31:0]  paddr_t;
  typedef logic [63:0]  dword_t;
  typedef logic [127:0] block_t;
  typedef logic [7:0]   index_t;
  typedef logic [2:0]   way_t;
  typedef logic [19:0]  ptag_t;
  typedef logic [3:0]   lce_id_t;

  // byte offset bits inside one block
  localparam int block_offset_w = 4;

  typedef enum logic [2:0]
  {
    e_size_1
    , e_size_2
    , e_size_4
    , e_size_8
    , e_size_16
  } msg_size_e;

  typedef enum logic [2:0]
  {
    e_req_miss_load
    , e_req_miss_store
    , e_req_uc_load
    , e_req_uc_store
    , e_req_clear
  } cache_req_type_e;

  typedef struct packed
  {
    cache_req_type_e msg_type;
    paddr_t          addr;
    msg_size_e       size;
    dword_t          data;
  } cache_req_s;

  typedef struct packed
  {
    way_t repl_way;
  } cache_req_meta_s;

  typedef enum logic [1:0]
  {
    e_mem_rd
    , e_mem_wr
    , e_mem_uc_rd
    , e_mem_uc_wr
  } mem_msg_type_e;

  typedef struct packed
  {
    mem_msg_type_e msg_type;
    paddr_t        addr;
    msg_size_e     size;
    way_t          way;
    lce_id_t       lce_id;
    block_t        data;
  } mem_msg_s;

  typedef enum logic {e_tag_set_clear, e_tag_set_tag} tag_op_e;
  typedef enum logic {e_coh_i, e_coh_m} coh_state_e;

  typedef struct packed
  {
    tag_op_e    opcode;
    index_t     index;
    way_t       way;
    ptag_t      tag;
    coh_state_e state;
  } tag_pkt_s;

  typedef enum logic {e_data_write, e_data_uncached} data_op_e;

  typedef struct packed
  {
    data_op_e opcode;
    index_t   index;
    way_t     way;
    block_t   data;
  } data_pkt_s;

  typedef enum logic {e_stat_set_clear} stat_op_e;

  typedef struct packed
  {
    stat_op_e opcode;
    index_t   index;
  } stat_pkt_s;

  typedef enum logic [2:0]
  {
    e_reset
    , e_clear
    , e_ready
    , e_send
    , e_fill_wait
    , e_uc_read_wait
  } ctrl_state_e;

endpackage

/* hdl/uce_req_capture.sv */
`timescale 1ns/10ps

module uce_req_capture
  (input                              clk_i
   , input                            reset_i
   , input  uce_pkg::cache_req_s      req_i
   , input                            accept_i
   , input                            complete_i
   , input  uce_pkg::cache_req_meta_s meta_i
   , input                            meta_v_i
   , output uce_pkg::cache_req_s      req_o
   , output logic                     req_v_o
   , output uce_pkg::cache_req_meta_s meta_o
   , output logic                     meta_v_o
  );

  import uce_pkg::*;

  // uncached stores leave in the accept cycle, nothing to hold
  wire hold_li = accept_i & (req_i.msg_type != e_req_uc_store);

  always_ff @(posedge clk_i)
  begin
    if (accept_i)
      req_o <= req_i;
    if (meta_v_i)
      meta_o <= meta_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_o  <= 1'b0;
      meta_v_o <= 1'b0;
    end
    else
    begin
      if (hold_li)
        req_v_o <= 1'b1;
      else if (complete_i)
        req_v_o <= 1'b0;
      // fresh metadata wins over the clear on accept
      if (meta_v_i)
        meta_v_o <= 1'b1;
      else if (accept_i)
        meta_v_o <= 1'b0;
    end
  end

  a_no_accept_while_held: assert property
    (@(posedge clk_i) disable iff (reset_i) accept_i |-> !req_v_o);

endmodule

/* hdl/uce_top.sv */
`timescale 1ns/10ps

module uce_top
  #(parameter int sets_p          = 64
    , parameter int assoc_p       = 8
    , parameter int max_credits_p = 4)
  (input                              clk_i
   , input                            reset_i
   , input  uce_pkg::lce_id_t         lce_id_i
   , input  uce_pkg::cache_req_s      req_i
   , input                            req_v_i
   , output logic                     req_yumi_o
   , output logic                     busy_o
   , output logic                     complete_o
   , input  uce_pkg::cache_req_meta_s meta_i
   , input                            meta_v_i
   , output uce_pkg::tag_pkt_s        tag_pkt_o
   , output logic                     tag_pkt_v_o
   , input                            tag_pkt_yumi_i
   , output uce_pkg::data_pkt_s       data_pkt_o
   , output logic                     data_pkt_v_o
   , input                            data_pkt_yumi_i
   , output uce_pkg::stat_pkt_s       stat_pkt_o
   , output logic                     stat_pkt_v_o
   , input                            stat_pkt_yumi_i
   , output uce_pkg::mem_msg_s        mem_cmd_o
   , output logic                     mem_cmd_v_o
   , input                            mem_cmd_ready_then_i
   , input  uce_pkg::mem_msg_s        mem_resp_i
   , input                            mem_resp_v_i
   , output logic                     mem_resp_yumi_o
  );

  import uce_pkg::*;

  cache_req_s      held_req;
  logic            held_req_v;
  cache_req_meta_s held_meta;
  logic            held_meta_v;
  logic            credits_full;
  logic            credits_empty;

  uce_req_capture u_capture
    (.clk_i      (clk_i)
     ,.reset_i   (reset_i)
     ,.req_i     (req_i)
     ,.accept_i  (req_yumi_o)
     ,.complete_i(complete_o)
     ,.meta_i    (meta_i)
     ,.meta_v_i  (meta_v_i)
     ,.req_o     (held_req)
     ,.req_v_o   (held_req_v)
     ,.meta_o    (held_meta)
     ,.meta_v_o  (held_meta_v)
    );

  // commands only assert valid when ready_then is high, so valid is a fire
  uce_credit_counter #(.max_credits_p(max_credits_p)) u_credits
    (.clk_i       (clk_i)
     ,.reset_i    (reset_i)
     ,.cmd_fire_i (mem_cmd_v_o)
     ,.resp_yumi_i(mem_resp_yumi_o)
     ,.full_o     (credits_full)
     ,.empty_o    (credits_empty)
    );

  uce_ctrl #(.sets_p(sets_p), .assoc_p(assoc_p)) u_ctrl
    (.clk_i                (clk_i)
     ,.reset_i             (reset_i)
     ,.lce_id_i            (lce_id_i)
     ,.req_i               (req_i)
     ,.req_v_i             (req_v_i)
     ,.req_yumi_o          (req_yumi_o)
     ,.busy_o              (busy_o)
     ,.complete_o          (complete_o)
     ,.held_req_i          (held_req)
     ,.held_req_v_i        (held_req_v)
     ,.meta_i              (held_meta)
     ,.meta_v_i            (held_meta_v)
     ,.credits_full_i      (credits_full)
     ,.credits_empty_i     (credits_empty)
     ,.tag_pkt_o           (tag_pkt_o)
     ,.tag_pkt_v_o         (tag_pkt_v_o)
     ,.tag_pkt_yumi_i      (tag_pkt_yumi_i)
     ,.data_pkt_o          (data_pkt_o)
     ,.data_pkt_v_o        (data_pkt_v_o)
     ,.data_pkt_yumi_i     (data_pkt_yumi_i)
     ,.stat_pkt_o          (stat_pkt_o)
     ,.stat_pkt_v_o        (stat_pkt_v_o)
     ,.stat_pkt_yumi_i     (stat_pkt_yumi_i)
     ,.mem_cmd_o           (mem_cmd_o)
     ,.mem_cmd_v_o         (mem_cmd_v_o)
     ,.mem_cmd_ready_then_i(mem_cmd_ready_then_i)
     ,.mem_resp_i          (mem_resp_i)
     ,.mem_resp_v_i        (mem_resp_v_i)
     ,.mem_resp_yumi_o     (mem_resp_yumi_o)
    );

endmodule

/* sim.f */
hdl/uce_pkg.sv
hdl/uce_req_capture.sv
hdl/uce_credit_counter.sv
hdl/uce_ctrl.sv
hdl/uce_top.sv
dv/tb_uce.sv
